//--- common/link_pkg.sv
/*
 * Serial link constants: byte width, bit counter width, comma character
 * and the number of aligned commas needed for lock, plus the byte type
 */
package link_pkg;

  // Width of one data byte on the link
  localparam int BYTE_W = 8;

  // Bit position counter inside one byte
  localparam int BIT_CNT_W = $clog2(BYTE_W);

  typedef logic [BYTE_W-1:0] byte_t;

  // Alignment and idle character
  localparam byte_t COMMA = 8'hBC;

  // Commas at consecutive byte boundaries before lock
  localparam int LOCK_COMMAS = 2;

endpackage : link_pkg

//--- common/buffer_pkg.sv
/*
 * Default lane FIFO sizing: depth and almost-full fill level
 */
package buffer_pkg;

  // Entries per lane FIFO
  localparam int DEFAULT_DEPTH = 4;

  // Fill count at which almost_full rises and the sender should slow down
  localparam int DEFAULT_AF_LEVEL = 3;

endpackage : buffer_pkg

//--- deserializer/serial_deserializer.sv
/*
 * Serial to byte converter for one lane: bit shifter, comma hunt,
 * lock state and byte strobe for non-comma bytes
 */
`timescale 1ns/1ps

module serial_deserializer (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            serial_in,
  output link_pkg::byte_t byte_data,
  output logic            byte_valid,
  output logic            locked
);

  localparam int BIT_CNT_W = link_pkg::BIT_CNT_W;
  localparam int CNT_W     = $clog2(link_pkg::LOCK_COMMAS + 1);

  typedef enum logic [1:0] {
    ST_HUNT,  // Comparing every cycle, no alignment yet
    ST_ALIGN, // Aligned, counting commas at boundaries
    ST_LOCK
  } state_t;

  state_t                 state;
  link_pkg::byte_t        shreg;
  logic [BIT_CNT_W-1:0]   bit_cnt;
  logic [CNT_W-1:0]       comma_cnt;
  logic [CNT_W-1:0]       next_cnt;
  logic                   is_comma;
  logic                   boundary;
  logic                   check_comma;

  assign is_comma = (shreg == link_pkg::COMMA);
  assign boundary = (bit_cnt == '0); // Shifter holds a whole aligned byte

  // A comma counts anywhere while hunting but only on a boundary once aligned
  assign check_comma = (state == ST_HUNT) ? is_comma : ((state == ST_ALIGN) && boundary);
  assign next_cnt    = (state == ST_HUNT) ? CNT_W'(1) : comma_cnt + CNT_W'(1);

  assign locked = (state == ST_LOCK);

  // MSB first so new bits enter at the bottom
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      shreg <= '0;
    end else begin
      shreg <= {shreg[link_pkg::BYTE_W-2:0], serial_in};
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= ST_HUNT;
      comma_cnt <= '0;
      bit_cnt   <= '0;
    end else begin
      bit_cnt <= bit_cnt + BIT_CNT_W'(1);
      if (check_comma && is_comma) begin
        // The bit shifted in on this edge is the first of the next byte
        bit_cnt   <= BIT_CNT_W'(1);
        comma_cnt <= next_cnt;
        if (next_cnt == CNT_W'(link_pkg::LOCK_COMMAS)) begin
          state <= ST_LOCK;
        end else begin
          state <= ST_ALIGN;
        end
      end else if (check_comma) begin
        state     <= ST_HUNT; // No comma at the boundary means a false alignment
        comma_cnt <= '0;
      end
    end
  end

  // Strobe on the edge after the last bit of a data byte was sampled
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      byte_valid <= 1'b0;
    end else begin
      byte_valid <= locked && boundary && !is_comma;
    end
  end

  always_ff @(posedge clk) begin
    if (locked && boundary) begin
      byte_data <= shreg;
    end
  end

  // Data only leaves a locked lane
  a_valid_needs_lock : assert property (
    @(posedge clk) disable iff (!rst_n)
      byte_valid |-> locked
  ) else $error("byte_valid while lane not locked");

endmodule : serial_deserializer

//--- logic/lane_fifo.sv
/*
 * Byte FIFO for one lane with combinational almost-full flag
 * and sticky overflow on a rejected push
 */
`timescale 1ns/1ps

module lane_fifo #(
  parameter int DEPTH    = buffer_pkg::DEFAULT_DEPTH,
  parameter int AF_LEVEL = buffer_pkg::DEFAULT_AF_LEVEL
) (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            push,
  input  link_pkg::byte_t push_data,
  input  logic            pop,
  output link_pkg::byte_t pop_data,
  output logic            empty,
  output logic            almost_full,
  output logic            overflow
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  link_pkg::byte_t   mem [DEPTH];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [CNT_W-1:0]  count;
  logic              full;
  logic              do_push;
  logic              do_pop;

  // Pointers wrap at DEPTH, which need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + PTR_W'(1);
  endfunction

  assign full        = (count == CNT_W'(DEPTH));
  assign empty       = (count == '0);
  assign almost_full = (count >= CNT_W'(AF_LEVEL));

  assign do_pop  = pop && !empty;
  assign do_push = push && (!full || do_pop); // A pop frees the slot in the same cycle

  assign pop_data = mem[rd_ptr]; // Head entry, shown before the pop

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + CNT_W'(1);
        2'b01:   count <= count - CNT_W'(1);
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      overflow <= 1'b0;
    end else if (push && !do_push) begin
      overflow <= 1'b1; // Byte lost, held until reset
    end
  end

  // The reader must never pop a lane it sees as empty
  a_no_pop_empty : assert property (
    @(posedge clk) disable iff (!rst_n) pop |-> !empty
  ) else $error("pop while FIFO empty");

  a_count_range : assert property (
    @(posedge clk) disable iff (!rst_n) count <= CNT_W'(DEPTH)
  ) else $error("FIFO count above DEPTH");

endmodule : lane_fifo

//--- logic/pair_reader.sv
/*
 * Joint pop of both lane FIFOs, registered output pair with valid
 * and registered almost-full flags for the sender
 */
`timescale 1ns/1ps

module pair_reader (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            read,
  input  link_pkg::byte_t data_a,
  input  link_pkg::byte_t data_b,
  input  logic            empty_a,
  input  logic            empty_b,
  input  logic            af_a,
  input  logic            af_b,
  output logic            pop,
  output link_pkg::byte_t data1,
  output link_pkg::byte_t data2,
  output logic            out_valid,
  output logic            almost_full1,
  output logic            almost_full2
);

  // Both lanes move together or not at all
  assign pop = read && !empty_a && !empty_b;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= pop; // One cycle per pop
    end
  end

  // Pair holds its value between pops
  always_ff @(posedge clk) begin
    if (pop) begin
      data1 <= data_a;
      data2 <= data_b;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      almost_full1 <= 1'b0;
      almost_full2 <= 1'b0;
    end else begin
      almost_full1 <= af_a; // One cycle behind the FIFO count
      almost_full2 <= af_b;
    end
  end

endmodule : pair_reader

//--- logic/dual_lane_receiver.sv
/*
 * Two-lane serial byte receiver: per lane a deserializer and a FIFO,
 * shared pair reader on the output side
 */
`timescale 1ns/1ps

module dual_lane_receiver #(
  parameter int DEPTH    = buffer_pkg::DEFAULT_DEPTH,
  parameter int AF_LEVEL = buffer_pkg::DEFAULT_AF_LEVEL
) (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            serial_in1,
  input  logic            serial_in2,
  input  logic            read,
  output link_pkg::byte_t data1,
  output link_pkg::byte_t data2,
  output logic            out_valid,
  output logic            almost_full1,
  output logic            almost_full2,
  output logic            overflow1,
  output logic            overflow2,
  output logic            locked1,
  output logic            locked2
);

  link_pkg::byte_t byte_data1;
  link_pkg::byte_t byte_data2;
  logic            byte_valid1;
  logic            byte_valid2;
  link_pkg::byte_t head1;
  link_pkg::byte_t head2;
  logic            empty1;
  logic            empty2;
  logic            af1;
  logic            af2;
  logic            pop;

  serial_deserializer u_des1 (
    .clk        (clk),
    .rst_n      (rst_n),
    .serial_in  (serial_in1),
    .byte_data  (byte_data1),
    .byte_valid (byte_valid1),
    .locked     (locked1)
  );

  serial_deserializer u_des2 (
    .clk        (clk),
    .rst_n      (rst_n),
    .serial_in  (serial_in2),
    .byte_data  (byte_data2),
    .byte_valid (byte_valid2),
    .locked     (locked2)
  );

  lane_fifo #(.DEPTH(DEPTH), .AF_LEVEL(AF_LEVEL)) u_fifo1 (
    .clk (clk), .rst_n (rst_n),
    .push (byte_valid1), .push_data (byte_data1),
    .pop (pop), .pop_data (head1),
    .empty (empty1), .almost_full (af1), .overflow (overflow1)
  );

  lane_fifo #(.DEPTH(DEPTH), .AF_LEVEL(AF_LEVEL)) u_fifo2 (
    .clk (clk), .rst_n (rst_n),
    .push (byte_valid2), .push_data (byte_data2),
    .pop (pop), .pop_data (head2),
    .empty (empty2), .almost_full (af2), .overflow (overflow2)
  );

  pair_reader u_reader (
    .clk (clk), .rst_n (rst_n), .read (read),
    .data_a (head1), .data_b (head2),
    .empty_a (empty1), .empty_b (empty2),
    .af_a (af1), .af_b (af2), .pop (pop),
    .data1 (data1), .data2 (data2), .out_valid (out_valid),
    .almost_full1 (almost_full1), .almost_full2 (almost_full2)
  );

endmodule : dual_lane_receiver

//--- verif/tb_lane_tasks.svh
/*
 * Testbench tasks: serial bit queuing, byte and pair send,
 * transmit drain, out_valid wait and value check
 */
`ifndef TB_LANE_TASKS_SVH
`define TB_LANE_TASKS_SVH

// MSB first onto one lane's transmit queue
task automatic queue_bits(input int lane, input link_pkg::byte_t value, input int n);
  for (int i = n - 1; i >= 0; i--) begin
    if (lane == 1) begin
      tx1.push_back(bit'(value >> i));
    end else begin
      tx2.push_back(bit'(value >> i));
    end
  end
endtask

// Commas are idle, and a full FIFO drops what the reader has not taken
task automatic queue_byte(input int lane, input link_pkg::byte_t b);
  queue_bits(lane, b, 8);
  if (b != link_pkg::COMMA && lane == 1 && model1.size() < DEPTH) begin
    model1.push_back(b);
  end
  if (b != link_pkg::COMMA && lane == 2 && model2.size() < DEPTH) begin
    model2.push_back(b);
  end
endtask

task automatic send_byte(input int lane, input link_pkg::byte_t b);
  @(negedge clk);
  queue_byte(lane, b);
endtask

task automatic send_pair(input link_pkg::byte_t a, input link_pkg::byte_t b);
  @(negedge clk);
  queue_byte(1, a);
  queue_byte(2, b);
endtask

// Lanes drain on their own bit phase, then the fixed lane latency
task automatic wait_drain();
  bit done1;
  bit done2;
  int n;
  done1 = 1'b0;
  done2 = 1'b0;
  n = 0;
  while (!(done1 && done2) && n < DRAIN_TIMEOUT) begin
    @(negedge clk);
    done1 |= (tx1.size() == 0);
    done2 |= (tx2.size() == 0);
    n++;
  end
  if (!(done1 && done2)) begin
    $display("Error: serial transmit did not drain within %0d cycles", DRAIN_TIMEOUT);
    errors++;
  end
  repeat (SETTLE_CYCLES) @(posedge clk);
  #2;
endtask

task automatic wait_valid(input int max_cycles, output bit seen);
  int n;
  seen = 1'b0;
  n = 0;
  while (!seen && n < max_cycles) begin
    @(posedge clk);
    #2;
    seen = out_valid;
    n++;
  end
endtask

task automatic check(input string name, input link_pkg::byte_t exp,
                     input link_pkg::byte_t act);
  checks++;
  if (exp !== act) begin
    $display("Fail %s: expected %02h, actual %02h", name, exp, act);
    errors++;
  end
endtask

`endif

//--- verif/tb_dual_lane_receiver.sv
/*
 * Testbench for the two-lane receiver: clock, reset, serial transmitters,
 * reference queues and directed tests
 */
`timescale 1ns/1ps

module tb_dual_lane_receiver;

  localparam int DEPTH         = buffer_pkg::DEFAULT_DEPTH;
  localparam int AF_LEVEL      = buffer_pkg::DEFAULT_AF_LEVEL;
  localparam int DRAIN_TIMEOUT = 200;
  localparam int SETTLE_CYCLES = 4; // Last bit sampled to registered almost_full
  localparam int READ_TIMEOUT  = 10;

  logic            clk = 1'b0;
  logic            rst_n;
  logic            serial_in1 = 1'b0;
  logic            serial_in2 = 1'b0;
  logic            read;
  link_pkg::byte_t data1;
  link_pkg::byte_t data2;
  logic            out_valid;
  logic            almost_full1;
  logic            almost_full2;
  logic            overflow1;
  logic            overflow2;
  logic            locked1;
  logic            locked2;

  bit              tx1[$];
  bit              tx2[$];
  bit              tx_en = 1'b0;
  link_pkg::byte_t model1[$];
  link_pkg::byte_t model2[$];
  int              errors;
  int              checks;
  int              tests_run;

  dual_lane_receiver #(.DEPTH(DEPTH), .AF_LEVEL(AF_LEVEL)) u_dut (.*);

  always #20 clk = ~clk;

  // Idle commas keep each lane byte aligned between sends
  always @(posedge clk) begin
    #2;
    if (tx_en && tx1.size() == 0) begin
      queue_bits(1, link_pkg::COMMA, 8);
    end
    if (tx_en && tx2.size() == 0) begin
      queue_bits(2, link_pkg::COMMA, 8);
    end
    serial_in1 = (tx1.size() != 0) ? tx1.pop_front() : 1'b0;
    serial_in2 = (tx2.size() != 0) ? tx2.pop_front() : 1'b0;
  end

  `include "tb_lane_tasks.svh"

  function automatic link_pkg::byte_t random_data();
    link_pkg::byte_t b;
    b = link_pkg::byte_t'($urandom());
    return (b == link_pkg::COMMA) ? 8'h00 : b; // Data never looks like idle
  endfunction

  task automatic pulse_read(input int max_cycles, output bit seen);
    @(posedge clk);
    #2;
    read = 1'b1;
    wait_valid(max_cycles, seen);
    read = 1'b0;
  endtask

  task automatic read_expect(input string name);
    bit seen;
    pulse_read(READ_TIMEOUT, seen);
    if (!seen) begin
      $display("Error %s: no out_valid within %0d cycles of read", name, READ_TIMEOUT);
      errors++;
    end else if (model1.size() == 0 || model2.size() == 0) begin
      $display("Error %s: out_valid with nothing left to deliver", name);
      errors++;
    end else begin
      check(name, model1.pop_front(), data1);
      check(name, model2.pop_front(), data2);
    end
  endtask

  task automatic read_none(input string name);
    bit seen;
    pulse_read(4, seen);
    if (seen) begin
      $display("Error %s: out_valid although a lane was empty", name);
      errors++;
    end
  endtask

  task automatic end_test(input string name, input int errs_before);
    tests_run++;
    if (errors == errs_before) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: %0d errors", name, errors - errs_before);
    end
  endtask

  task automatic test_reset();
    int e0;
    e0 = errors;
    check("reset_state", 8'h00, {1'b0, locked1, locked2, out_valid,
                                 almost_full1, almost_full2, overflow1, overflow2});
    read_none("reset_state");
    end_test("reset_state", e0);
  endtask

  task automatic test_lock();
    int e0;
    e0 = errors;
    @(negedge clk);
    queue_bits(1, 8'h03, 3); // Misaligned junk ahead of the commas
    queue_bits(2, 8'h12, 5);
    repeat (link_pkg::LOCK_COMMAS) begin
      queue_byte(1, link_pkg::COMMA);
      queue_byte(2, link_pkg::COMMA);
    end
    tx_en = 1'b1;
    wait_drain();
    check("lock", 8'h03, {6'b0, locked1, locked2});
    send_pair(8'h5A, 8'hC3);
    wait_drain();
    read_expect("lock_first_pair");
    end_test("lock_first_pair", e0);
  endtask

  task automatic test_idle_order();
    int e0;
    e0 = errors;
    for (int i = 0; i < 3; i++) begin
      send_pair(link_pkg::COMMA, link_pkg::COMMA);
      send_pair(8'(8'h10 + i), 8'(8'h20 + i));
    end
    wait_drain();
    repeat (3) read_expect("idle_drop_order");
    end_test("idle_drop_order", e0);
  endtask

  task automatic test_one_lane();
    int e0;
    e0 = errors;
    send_byte(1, 8'h66);
    wait_drain();
    read_none("one_lane_empty");
    send_byte(2, 8'h99);
    wait_drain();
    read_expect("one_lane_empty");
    end_test("one_lane_empty", e0);
  endtask

  task automatic test_fill();
    int e0;
    e0 = errors;
    for (int i = 0; i < DEPTH + 1; i++) begin
      send_pair(8'(8'h40 + i), 8'(8'h80 + i));
      wait_drain();
      check("fill_almost_full", 8'(i >= AF_LEVEL - 1), 8'(almost_full1));
      check("fill_almost_full", 8'(i >= AF_LEVEL - 1), 8'(almost_full2));
      check("fill_overflow", 8'(i >= DEPTH), 8'(overflow1));
      check("fill_overflow", 8'(i >= DEPTH), 8'(overflow2));
    end
    repeat (DEPTH) read_expect("fill_drain");
    read_none("fill_drain");
    end_test("fill_overflow", e0);
  endtask

  task automatic test_random();
    int e0;
    e0 = errors;
    for (int i = 0; i < 20; i++) begin
      send_pair(random_data(), random_data());
      wait_drain();
      read_expect("random_stream");
    end
    end_test("random_stream", e0);
  endtask

  initial begin
    void'($urandom(32'h3333f88e));
    rst_n     = 1'b0;
    read      = 1'b0;
    errors    = 0;
    checks    = 0;
    tests_run = 0;
    repeat (3) @(posedge clk);
    #2;
    rst_n = 1'b1;
    test_reset();
    test_lock();
    test_idle_order();
    test_one_lane();
    test_fill();
    test_random();
    $display("Tests run: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule : tb_dual_lane_receiver

//--- dual_lane_receiver.f
+incdir+verif
common/link_pkg.sv
common/buffer_pkg.sv
deserializer/serial_deserializer.sv
logic/lane_fifo.sv
logic/pair_reader.sv
logic/dual_lane_receiver.sv
verif/tb_dual_lane_receiver.sv

//--- Makefile
# Verilator build and run for the dual-lane receiver testbench
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_dual_lane_receiver
FILELIST  ?= dual_lane_receiver.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Testbench failed" $(LOG); then echo "Result: FAIL"; exit 1; fi
	@if ! grep -q "Testbench passed" $(LOG); then echo "Result: FAIL, no result line"; exit 1; fi
	@echo "Result: PASS"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
